// File: Makefile
# Verilator build and run of the AXI4-Lite register subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_axi4l_reg_subsys
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: axi4l_pipe/axi4l_pipe.sv
// *************************************************************************
// Pipelines all five AXI4-Lite channels in the valid and the ready direction
// *************************************************************************
`include "axi4l_defines.svh"

module axi4l_pipe
    import axi4l_pkg::*;
#(
    parameter int STAGES = `AXI4L_PIPE_STAGES
) (
    input logic           rst,
    axi4l_intf.peripheral from_controller,
    axi4l_intf.controller to_peripheral
);

    logic        aclk;
    ax_payload_t aw_in;
    ax_payload_t aw_out;
    w_payload_t  w_in;
    w_payload_t  w_out;
    b_payload_t  b_in;
    b_payload_t  b_out;
    ax_payload_t ar_in;
    ax_payload_t ar_out;
    r_payload_t  r_in;
    r_payload_t  r_out;

    assign aclk = from_controller.aclk;

    // Pack on the sending side of each channel
    assign aw_in = '{prot: from_controller.awprot, addr: from_controller.awaddr};
    assign w_in  = '{data: from_controller.wdata, strb: from_controller.wstrb};
    assign ar_in = '{prot: from_controller.arprot, addr: from_controller.araddr};
    assign b_in  = '{resp: to_peripheral.bresp};
    assign r_in  = '{data: to_peripheral.rdata, resp: to_peripheral.rresp};

    // Forward channels
    bus_pipe #(.STAGES(STAGES), .DATA_T(ax_payload_t)) i_bus_pipe_aw (
        .aclk, .rst,
        .in_valid(from_controller.awvalid), .in_ready(from_controller.awready),
        .in_data(aw_in), .out_valid(to_peripheral.awvalid),
        .out_ready(to_peripheral.awready), .out_data(aw_out)
    );

    bus_pipe #(.STAGES(STAGES), .DATA_T(w_payload_t)) i_bus_pipe_w (
        .aclk, .rst,
        .in_valid(from_controller.wvalid), .in_ready(from_controller.wready),
        .in_data(w_in), .out_valid(to_peripheral.wvalid),
        .out_ready(to_peripheral.wready), .out_data(w_out)
    );

    bus_pipe #(.STAGES(STAGES), .DATA_T(ax_payload_t)) i_bus_pipe_ar (
        .aclk, .rst,
        .in_valid(from_controller.arvalid), .in_ready(from_controller.arready),
        .in_data(ar_in), .out_valid(to_peripheral.arvalid),
        .out_ready(to_peripheral.arready), .out_data(ar_out)
    );

    // Reverse channels run from the peripheral back to the controller
    bus_pipe #(.STAGES(STAGES), .DATA_T(b_payload_t)) i_bus_pipe_b (
        .aclk, .rst,
        .in_valid(to_peripheral.bvalid), .in_ready(to_peripheral.bready),
        .in_data(b_in), .out_valid(from_controller.bvalid),
        .out_ready(from_controller.bready), .out_data(b_out)
    );

    bus_pipe #(.STAGES(STAGES), .DATA_T(r_payload_t)) i_bus_pipe_r (
        .aclk, .rst,
        .in_valid(to_peripheral.rvalid), .in_ready(to_peripheral.rready),
        .in_data(r_in), .out_valid(from_controller.rvalid),
        .out_ready(from_controller.rready), .out_data(r_out)
    );

    // Unpack on the receiving side
    assign to_peripheral.awprot  = aw_out.prot;
    assign to_peripheral.awaddr  = aw_out.addr;
    assign to_peripheral.wdata   = w_out.data;
    assign to_peripheral.wstrb   = w_out.strb;
    assign to_peripheral.arprot  = ar_out.prot;
    assign to_peripheral.araddr  = ar_out.addr;
    assign from_controller.bresp = b_out.resp;
    assign from_controller.rdata = r_out.data;
    assign from_controller.rresp = r_out.resp;

endmodule

// File: axi4l_pipe/bus_pipe.sv
// *************************************************************************
// Chain of full-throughput register slices for one valid/ready channel
// Both valid/data and ready are registered in every slice
// *************************************************************************
module bus_pipe
    import axi4l_pkg::*;
#(
    parameter int  STAGES = 1,
    parameter type DATA_T = ax_payload_t
) (
    input  logic  aclk,
    input  logic  rst,
    input  logic  in_valid,
    output logic  in_ready,
    input  DATA_T in_data,
    output logic  out_valid,
    input  logic  out_ready,
    output DATA_T out_data
);

    if (STAGES == 0)
    begin : g_bypass
        assign out_valid = in_valid;
        assign in_ready  = out_ready;
        assign out_data  = in_data;
    end
    else
    begin : g_slices
        // Index i is the input side of slice i
        logic [STAGES:0] valid;
        logic [STAGES:0] ready;
        DATA_T           data [STAGES+1];

        assign valid[0]  = in_valid;
        assign in_ready  = ready[0];
        assign data[0]   = in_data;
        assign out_valid = valid[STAGES];
        assign ready[STAGES] = out_ready;
        assign out_data  = data[STAGES];

        for (genvar i = 0; i < STAGES; i++)
        begin : g_slice
            logic  main_valid;
            logic  skid_valid;
            logic  ready_q;
            DATA_T main_data;
            DATA_T skid_data;
            logic  take;
            logic  drain;

            assign take  = valid[i] && ready_q;
            // Output register can load this cycle
            assign drain = !main_valid || ready[i+1];

            always_ff @(posedge aclk)
            begin
                if (rst)
                begin
                    main_valid <= 1'b0;
                    skid_valid <= 1'b0;
                    ready_q    <= 1'b0;
                end
                else if (drain)
                begin
                    main_valid <= skid_valid || take;
                    skid_valid <= 1'b0;
                    ready_q    <= 1'b1;
                end
                else
                begin
                    skid_valid <= skid_valid || take;
                    ready_q    <= !(skid_valid || take);
                end
            end

            always_ff @(posedge aclk)
            begin
                if (drain)
                    main_data <= skid_valid ? skid_data : data[i];
                else if (take)
                    skid_data <= data[i];
            end

            assign valid[i+1] = main_valid;
            assign ready[i]   = ready_q;
            assign data[i+1]  = main_data;
        end
    end

endmodule

// File: common/axi4l_defines.svh
// *************************************************************************
// Build-time sizes of the AXI4-Lite register subsystem
// Include wherever address, data or pipeline sizing is needed
// *************************************************************************
`ifndef AXI4L_DEFINES_SVH
`define AXI4L_DEFINES_SVH

// Byte address width of the peripheral
`define AXI4L_ADDR_WID 8

// Bytes per data word
`define AXI4L_DATA_BYTE_WID 4

// Register slices per channel, both directions
`define AXI4L_PIPE_STAGES 2

// Read/write registers, counter sits right after them
`define AXI4L_NUM_REGS 8

`endif

// File: common/axi4l_intf.sv
// *************************************************************************
// AXI4-Lite bus bundle with controller and peripheral views
// *************************************************************************
interface axi4l_intf
    import axi4l_pkg::*;
(
    input logic aclk
);

    logic  awvalid;
    logic  awready;
    addr_t awaddr;
    prot_t awprot;

    logic  wvalid;
    logic  wready;
    data_t wdata;
    strb_t wstrb;

    logic  bvalid;
    logic  bready;
    resp_t bresp;

    logic  arvalid;
    logic  arready;
    addr_t araddr;
    prot_t arprot;

    logic  rvalid;
    logic  rready;
    data_t rdata;
    resp_t rresp;

    modport controller (
        input  aclk,
        output awvalid, awaddr, awprot, input awready,
        output wvalid, wdata, wstrb, input wready,
        input  bvalid, bresp, output bready,
        output arvalid, araddr, arprot, input arready,
        input  rvalid, rdata, rresp, output rready
    );

    modport peripheral (
        input  aclk,
        input  awvalid, awaddr, awprot, output awready,
        input  wvalid, wdata, wstrb, output wready,
        output bvalid, bresp, input bready,
        input  arvalid, araddr, arprot, output arready,
        output rvalid, rdata, rresp, input rready
    );

endinterface

// File: common/axi4l_pkg.sv
// *************************************************************************
// Shared types for the AXI4-Lite register subsystem
// Response codes, bus field types and per-channel payload structs
// *************************************************************************
`include "axi4l_defines.svh"

package axi4l_pkg;

    localparam int ADDR_WID = `AXI4L_ADDR_WID;
    localparam int STRB_WID = `AXI4L_DATA_BYTE_WID;
    localparam int DATA_WID = `AXI4L_DATA_BYTE_WID * 8;
    localparam int REG_IDX_WID = $clog2(`AXI4L_NUM_REGS);

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_t;

    typedef logic [ADDR_WID-1:0]    addr_t;
    typedef logic [DATA_WID-1:0]    data_t;
    typedef logic [STRB_WID-1:0]    strb_t;
    typedef logic [2:0]             prot_t;
    typedef logic [REG_IDX_WID-1:0] reg_idx_t;

    // Shared by aw and ar
    typedef struct packed {
        prot_t prot;
        addr_t addr;
    } ax_payload_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_payload_t;

    typedef struct packed {
        resp_t resp;
    } b_payload_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } r_payload_t;

endpackage

// File: design/axi4l_reg_fsm.sv
// *************************************************************************
// AXI4-Lite peripheral FSM that handles one transaction at a time
// Decodes register, counter and unmapped space and returns the response
// *************************************************************************
`include "axi4l_defines.svh"

module axi4l_reg_fsm
    import axi4l_pkg::*;
(
    input  logic          aclk,
    input  logic          rst,
    axi4l_intf.peripheral axi,
    output logic          reg_we,
    output reg_idx_t      reg_addr,
    output data_t         reg_wdata,
    output strb_t         reg_wstrb,
    input  data_t         reg_rdata,
    input  data_t         count
);

    typedef enum logic [1:0] {IDLE, WRITE_RESP, READ_DATA, READ_RESP} state_t;
    typedef enum logic [1:0] {SEL_REG, SEL_CNT, SEL_NONE} sel_t;

    state_t state;
    sel_t   wr_sel;
    sel_t   rd_sel;
    logic   wr_go;
    logic   rd_go;
    addr_t  rd_addr_q;
    resp_t  bresp_q;
    resp_t  rresp_q;
    data_t  rdata_q;

    // Low two address bits are byte offsets and are ignored
    function automatic sel_t decode(addr_t addr);
        logic [ADDR_WID-3:0] word;
        word = addr[ADDR_WID-1:2];
        if (word < `AXI4L_NUM_REGS)
            return SEL_REG;
        else if (word == `AXI4L_NUM_REGS)
            return SEL_CNT;
        else
            return SEL_NONE;
    endfunction

    // Write wins when both are waiting
    assign wr_go  = (state == IDLE) && axi.awvalid && axi.wvalid;
    assign rd_go  = (state == IDLE) && axi.arvalid && !(axi.awvalid && axi.wvalid);
    assign wr_sel = decode(axi.awaddr);
    assign rd_sel = decode(rd_addr_q);

    always_ff @(posedge aclk)
    begin
        if (rst)
            state <= IDLE;
        else
        begin
            case (state)
                IDLE:
                begin
                    if (wr_go)
                        state <= WRITE_RESP;
                    else if (rd_go)
                        state <= READ_DATA;
                end
                WRITE_RESP:
                    if (axi.bready)
                        state <= IDLE;
                READ_DATA:
                    state <= READ_RESP;
                default:
                    if (axi.rready)
                        state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (wr_go)
        begin
            case (wr_sel)
                SEL_REG: bresp_q <= OKAY;
                SEL_CNT: bresp_q <= SLVERR;
                default: bresp_q <= DECERR;
            endcase
        end
        if (rd_go)
            rd_addr_q <= axi.araddr;
        // Read data is registered one cycle after the ar transfer
        if (state == READ_DATA)
        begin
            rresp_q <= (rd_sel == SEL_NONE) ? DECERR : OKAY;
            case (rd_sel)
                SEL_REG: rdata_q <= reg_rdata;
                SEL_CNT: rdata_q <= count;
                default: rdata_q <= '0;
            endcase
        end
    end

    // Register port shared by the write in IDLE and the read in READ_DATA
    assign reg_we    = wr_go && (wr_sel == SEL_REG);
    assign reg_addr  = (state == IDLE) ? axi.awaddr[2 +: REG_IDX_WID]
                                       : rd_addr_q[2 +: REG_IDX_WID];
    assign reg_wdata = axi.wdata;
    assign reg_wstrb = axi.wstrb;

    assign axi.awready = wr_go;
    assign axi.wready  = wr_go;
    assign axi.arready = rd_go;
    assign axi.bvalid  = (state == WRITE_RESP);
    assign axi.bresp   = bresp_q;
    assign axi.rvalid  = (state == READ_RESP);
    assign axi.rdata   = rdata_q;
    assign axi.rresp   = rresp_q;

endmodule

// File: design/axi4l_reg_subsys.sv
// *************************************************************************
// Top level of the AXI4-Lite register subsystem
// Plain AXI4-Lite ports in, channel pipeline, then the register peripheral
// *************************************************************************
`include "axi4l_defines.svh"

module axi4l_reg_subsys
    import axi4l_pkg::*;
(
    input  logic  aclk,
    input  logic  rst,
    input  logic  awvalid,
    output logic  awready,
    input  addr_t awaddr,
    input  prot_t awprot,
    input  logic  wvalid,
    output logic  wready,
    input  data_t wdata,
    input  strb_t wstrb,
    output logic  bvalid,
    input  logic  bready,
    output resp_t bresp,
    input  logic  arvalid,
    output logic  arready,
    input  addr_t araddr,
    input  prot_t arprot,
    output logic  rvalid,
    input  logic  rready,
    output data_t rdata,
    output resp_t rresp
);

    logic     reg_we;
    reg_idx_t reg_addr;
    data_t    reg_wdata;
    strb_t    reg_wstrb;
    data_t    reg_rdata;
    data_t    count;

    axi4l_intf ctrl_if (.aclk);
    axi4l_intf periph_if (.aclk);

    // External controller side
    assign ctrl_if.awvalid = awvalid;
    assign awready         = ctrl_if.awready;
    assign ctrl_if.awaddr  = awaddr;
    assign ctrl_if.awprot  = awprot;
    assign ctrl_if.wvalid  = wvalid;
    assign wready          = ctrl_if.wready;
    assign ctrl_if.wdata   = wdata;
    assign ctrl_if.wstrb   = wstrb;
    assign bvalid          = ctrl_if.bvalid;
    assign ctrl_if.bready  = bready;
    assign bresp           = ctrl_if.bresp;
    assign ctrl_if.arvalid = arvalid;
    assign arready         = ctrl_if.arready;
    assign ctrl_if.araddr  = araddr;
    assign ctrl_if.arprot  = arprot;
    assign rvalid          = ctrl_if.rvalid;
    assign ctrl_if.rready  = rready;
    assign rdata           = ctrl_if.rdata;
    assign rresp           = ctrl_if.rresp;

    axi4l_pipe #(.STAGES(`AXI4L_PIPE_STAGES)) i_axi4l_pipe (
        .rst,
        .from_controller(ctrl_if),
        .to_peripheral(periph_if)
    );

    axi4l_reg_fsm i_axi4l_reg_fsm (
        .aclk, .rst,
        .axi(periph_if),
        .reg_we, .reg_addr, .reg_wdata, .reg_wstrb, .reg_rdata,
        .count
    );

    reg_file #(.NUM_REGS(`AXI4L_NUM_REGS)) i_reg_file (
        .aclk, .rst,
        .we(reg_we), .addr(reg_addr), .wdata(reg_wdata), .wstrb(reg_wstrb),
        .rdata(reg_rdata)
    );

    cycle_counter i_cycle_counter (
        .aclk, .rst,
        .count
    );

endmodule

// File: design/cycle_counter.sv
// *************************************************************************
// Free-running cycle counter, wraps at full scale
// *************************************************************************
module cycle_counter
    import axi4l_pkg::*;
(
    input  logic  aclk,
    input  logic  rst,
    output data_t count
);

    always_ff @(posedge aclk)
    begin
        if (rst)
            count <= '0;
        else
            count <= count + 1'b1;
    end

endmodule

// File: design/reg_file.sv
// *************************************************************************
// Read/write register bank with byte-lane strobes
// Read port is combinational
// *************************************************************************
`include "axi4l_defines.svh"

module reg_file
    import axi4l_pkg::*;
#(
    parameter int NUM_REGS = `AXI4L_NUM_REGS
) (
    input  logic                        aclk,
    input  logic                        rst,
    input  logic                        we,
    input  logic [$clog2(NUM_REGS)-1:0] addr,
    input  data_t                       wdata,
    input  strb_t                       wstrb,
    output data_t                       rdata
);

    data_t regs [NUM_REGS];

    always_ff @(posedge aclk)
    begin
        if (rst)
            regs <= '{default: '0};
        else if (we)
        begin
            // Only strobed lanes change
            for (int b = 0; b < STRB_WID; b++)
                if (wstrb[b])
                    regs[addr][8*b +: 8] <= wdata[8*b +: 8];
        end
    end

    assign rdata = regs[addr];

endmodule

// File: dv/axi4l_reg_asserts.sv
// *************************************************************************
// Handshake assertions on the top-level AXI4-Lite ports
// Attached to the subsystem top level with bind
// *************************************************************************
module axi4l_reg_asserts
    import axi4l_pkg::*;
(
    input logic  aclk,
    input logic  rst,
    input logic  awvalid,
    input logic  awready,
    input addr_t awaddr,
    input prot_t awprot,
    input logic  wvalid,
    input logic  wready,
    input data_t wdata,
    input strb_t wstrb,
    input logic  bvalid,
    input logic  bready,
    input resp_t bresp,
    input logic  arvalid,
    input logic  arready,
    input addr_t araddr,
    input prot_t arprot,
    input logic  rvalid,
    input logic  rready,
    input data_t rdata,
    input resp_t rresp
);

    timeunit 1ns;
    timeprecision 100ps;

    // Valid holds with a stable payload until the transfer
    a_aw_hold: assert property (@(posedge aclk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable({awaddr, awprot}))
        else $error("aw channel dropped valid or changed payload before awready");

    a_w_hold: assert property (@(posedge aclk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable({wdata, wstrb}))
        else $error("w channel dropped valid or changed payload before wready");

    a_ar_hold: assert property (@(posedge aclk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable({araddr, arprot}))
        else $error("ar channel dropped valid or changed payload before arready");

    a_b_hold: assert property (@(posedge aclk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("b channel dropped valid or changed payload before bready");

    a_r_hold: assert property (@(posedge aclk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable({rdata, rresp}))
        else $error("r channel dropped valid or changed payload before rready");

    // First reset edge only clears the registers
    a_reset_quiet: assert property (@(posedge aclk)
        rst && $past(rst) |-> !(awvalid || wvalid || arvalid || bvalid || rvalid))
        else $error("valid high on a channel during reset");

endmodule

bind axi4l_reg_subsys axi4l_reg_asserts i_axi4l_reg_asserts (.*);

// File: dv/tb_axi4l_reg_subsys.sv
// *************************************************************************
// Testbench for the AXI4-Lite register subsystem
// Drives random register, counter and unmapped accesses against a model
// *************************************************************************
`include "axi4l_defines.svh"

module tb_axi4l_reg_subsys
    import axi4l_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    TIMEOUT_CYCLES = 200;
    localparam int    NUM_REGS = `AXI4L_NUM_REGS;
    localparam addr_t CNT_ADDR = addr_t'(NUM_REGS * 4);

    typedef struct packed {
        logic  is_cnt;
        resp_t resp;
        data_t data;
    } exp_read_t;

    logic  aclk;
    logic  rst;
    logic  awvalid;
    logic  awready;
    addr_t awaddr;
    prot_t awprot;
    logic  wvalid;
    logic  wready;
    data_t wdata;
    strb_t wstrb;
    logic  bvalid;
    logic  bready;
    resp_t bresp;
    logic  arvalid;
    logic  arready;
    addr_t araddr;
    prot_t arprot;
    logic  rvalid;
    logic  rready;
    data_t rdata;
    resp_t rresp;

    data_t       model [NUM_REGS];
    resp_t       exp_b [$];
    exp_read_t   exp_r [$];
    logic [15:0] data_lfsr;
    logic [15:0] ready_lfsr;
    logic        bp_on;
    data_t       last_count;

    tb_clk_gen i_tb_clk_gen (.aclk, .rst);

    axi4l_reg_subsys i_axi4l_reg_subsys (.*);

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0])
            next = next ^ 16'hB400;
        return next;
    endfunction

    function automatic logic [31:0] take_bits(inout logic [15:0] state, input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            bits[i] = state[0];
            state = lfsr_next(state);
        end
        return bits;
    endfunction

    // Register address with random byte offset
    function automatic addr_t rand_reg_addr();
        logic [31:0] word;
        logic [31:0] offset;
        word = take_bits(data_lfsr, REG_IDX_WID);
        offset = take_bits(data_lfsr, 2);
        return addr_t'(word * 4 + offset);
    endfunction

    // Anything from 0x24 up is unmapped
    function automatic addr_t unmapped_addr();
        logic [31:0] bits;
        bits = take_bits(data_lfsr, 8);
        return addr_t'(32'h24 + bits % 32'hDC);
    endfunction

    // Expected response and read data and the effect of a write on the model
    function automatic resp_t model_resp(input addr_t addr, input logic is_write,
                                         input data_t wd, input strb_t ws,
                                         output data_t rd, output logic is_cnt);
        int word;
        word = int'(addr[ADDR_WID-1:2]);
        rd = '0;
        is_cnt = 1'b0;
        if (word < NUM_REGS)
        begin
            if (is_write)
                for (int b = 0; b < STRB_WID; b++)
                    if (ws[b])
                        model[word][8*b +: 8] = wd[8*b +: 8];
            rd = model[word];
            return OKAY;
        end
        if (word == NUM_REGS)
        begin
            is_cnt = !is_write;
            return is_write ? SLVERR : OKAY;
        end
        return DECERR;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Error: time %0t: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "Mismatch in %s", what);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Finished with errors");
        $fatal(1, "Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
    endtask

    task automatic report_unexpected(input string what);
        $display("Finished with errors");
        $fatal(1, "A %s arrived with no request outstanding", what);
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        @(negedge aclk);
        while (rst)
        begin
            @(negedge aclk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                report_timeout("reset release");
        end
    endtask

    // Called and returns on a falling edge
    task automatic send_write(input addr_t addr, input data_t data, input strb_t strb);
        logic  aw_done;
        logic  w_done;
        int    cycles;
        data_t rd_unused;
        logic  cnt_unused;
        aw_done = 1'b0;
        w_done = 1'b0;
        cycles = 0;
        awvalid = 1'b1;
        awaddr = addr;
        awprot = prot_t'(take_bits(data_lfsr, 3));
        wvalid = 1'b1;
        wdata = data;
        wstrb = strb;
        while (!(aw_done && w_done))
        begin
            @(posedge aclk);
            if (awvalid && awready)
                aw_done = 1'b1;
            if (wvalid && wready)
                w_done = 1'b1;
            @(negedge aclk);
            if (aw_done)
                awvalid = 1'b0;
            if (w_done)
                wvalid = 1'b0;
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                report_timeout("awready and wready");
        end
        exp_b.push_back(model_resp(addr, 1'b1, data, strb, rd_unused, cnt_unused));
    endtask

    task automatic send_read(input addr_t addr);
        int        cycles;
        logic      done;
        exp_read_t item;
        cycles = 0;
        done = 1'b0;
        arvalid = 1'b1;
        araddr = addr;
        arprot = prot_t'(take_bits(data_lfsr, 3));
        while (!done)
        begin
            @(posedge aclk);
            done = arvalid && arready;
            @(negedge aclk);
            if (done)
                arvalid = 1'b0;
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                report_timeout("arready");
        end
        item.resp = model_resp(addr, 1'b0, '0, '0, item.data, item.is_cnt);
        exp_r.push_back(item);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_b.size() != 0 || exp_r.size() != 0)
        begin
            @(negedge aclk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                report_timeout("outstanding responses");
        end
    endtask

    // The FSM serves a waiting write ahead of an earlier read
    task automatic wait_reads();
        int cycles;
        cycles = 0;
        while (exp_r.size() != 0)
        begin
            @(negedge aclk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                report_timeout("outstanding read responses");
        end
    endtask

    task automatic read_all();
        for (int i = 0; i < NUM_REGS; i++)
            send_read(addr_t'(i * 4));
        wait_drain();
    endtask

    // Response ready patterns
    initial
    begin
        bready = 1'b0;
        rready = 1'b0;
        forever
        begin
            @(negedge aclk);
            if (bp_on)
            begin
                bready = |take_bits(ready_lfsr, 2);
                rready = |take_bits(ready_lfsr, 2);
            end
            else
            begin
                bready = !rst;
                rready = !rst;
            end
        end
    end

    // Compare each response with the oldest expected one
    initial
    begin
        exp_read_t exp_rd;
        forever
        begin
            @(posedge aclk);
            if (!rst && bvalid && bready)
            begin
                if (exp_b.size() == 0)
                    report_unexpected("write response");
                check_value(32'(bresp), 32'(exp_b.pop_front()), "write response");
            end
            if (!rst && rvalid && rready)
            begin
                if (exp_r.size() == 0)
                    report_unexpected("read response");
                exp_rd = exp_r.pop_front();
                if (exp_rd.is_cnt)
                begin
                    check_value(32'(rdata > last_count), 32'd1, "counter increase");
                    last_count = rdata;
                end
                else
                    check_value(rdata, exp_rd.data, "read data");
                check_value(32'(rresp), 32'(exp_rd.resp), "read response");
            end
        end
    end

    initial
    begin
        addr_t a;
        data_t d;
        strb_t s;
        awvalid = 1'b0;
        awaddr = '0;
        awprot = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        arvalid = 1'b0;
        araddr = '0;
        arprot = '0;
        data_lfsr = 16'd54;
        ready_lfsr = 16'd54;
        bp_on = 1'b0;
        last_count = '0;
        for (int i = 0; i < NUM_REGS; i++)
            model[i] = '0;
        wait_reset();

        // Registers come out of reset as zero
        read_all();

        for (int i = 0; i < NUM_REGS; i++)
            send_write(addr_t'(i * 4), take_bits(data_lfsr, 32), 4'hF);
        read_all();

        // Partial strobes
        repeat (16)
        begin
            a = rand_reg_addr();
            d = take_bits(data_lfsr, 32);
            s = strb_t'(take_bits(data_lfsr, STRB_WID));
            send_write(a, d, s);
        end
        read_all();

        // Back-to-back mixed traffic with response back-pressure
        bp_on = 1'b1;
        repeat (40)
        begin
            a = rand_reg_addr();
            if (take_bits(data_lfsr, 1) != 0)
            begin
                d = take_bits(data_lfsr, 32);
                s = strb_t'(take_bits(data_lfsr, STRB_WID));
                wait_reads();
                send_write(a, d, s);
            end
            else
                send_read(a);
        end
        wait_drain();
        bp_on = 1'b0;

        // Counter reads followed by a rejected counter write
        send_read(CNT_ADDR);
        send_read(CNT_ADDR + addr_t'(3));
        send_write(CNT_ADDR, take_bits(data_lfsr, 32), 4'hF);
        read_all();

        repeat (8)
        begin
            a = unmapped_addr();
            send_write(a, take_bits(data_lfsr, 32), 4'hF);
            a = unmapped_addr();
            send_read(a);
        end
        read_all();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: dv/tb_clk_gen.sv
// *************************************************************************
// Testbench clock and synchronous reset, 20 ns period, 3 reset cycles
// *************************************************************************
module tb_clk_gen (
    output logic aclk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        aclk = 1'b0;
        forever
            #10 aclk = ~aclk;
    end

    // Released right after the third rising edge
    initial
    begin
        rst = 1'b1;
        repeat (3) @(posedge aclk);
        rst <= 1'b0;
    end

endmodule

// File: verilog.f
+incdir+common
common/axi4l_pkg.sv
common/axi4l_intf.sv
axi4l_pipe/bus_pipe.sv
axi4l_pipe/axi4l_pipe.sv
design/reg_file.sv
design/cycle_counter.sv
design/axi4l_reg_fsm.sv
design/axi4l_reg_subsys.sv
dv/tb_clk_gen.sv
dv/axi4l_reg_asserts.sv
dv/tb_axi4l_reg_subsys.sv
